// File: Makefile
SRCS := $(wildcard common/*.sv backup/*.sv source/*.sv sim/*.sv)

.PHONY: all run check clean

all: check

obj_dir/tb_backup: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_backup \
		-f flist.f --Mdir obj_dir -o tb_backup

sim.log: obj_dir/tb_backup
	./obj_dir/tb_backup > sim.log; cat sim.log

run: sim.log

check: run
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: backup/bk_lba_counter.sv
`default_nettype none

module bk_lba_counter
	import bk_pkg::*;
#(
	parameter int LBA_W = 12
)
(
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             img_mounted,
	input  logic [31:0]      img_size,
	input  logic             clear,
	input  logic             step,
	output logic [LBA_W-1:0] sd_lba,
	output logic             last_sector,
	output logic             img_nonzero
);

	logic                        mounted_d;
	logic [LBA_W-1:0]            last_idx;
	logic [31-SECTOR_BYTES_W:0]  img_sectors;

	// Image size in whole sectors
	assign img_sectors = img_size[31:SECTOR_BYTES_W];

	assign last_sector = (sd_lba == last_idx);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mounted_d   <= 1'b0;
			last_idx    <= '0;
			img_nonzero <= 1'b0;
			sd_lba      <= '0;
		end else begin
			mounted_d <= img_mounted;

			// Latched on the mount edge, ready for the sequencer a cycle later
			// Images under one sector count as empty
			if (img_mounted && !mounted_d) begin
				last_idx    <= img_sectors[LBA_W-1:0] - 1'b1;
				img_nonzero <= |img_sectors;
			end

			if (clear)
				sd_lba <= '0;
			else if (step)
				sd_lba <= sd_lba + 1'b1;
		end
	end

	// Sequencer stops at the stored last index and never runs past it
	assert property (@(posedge clk_sys) disable iff (reset) step |-> !last_sector)
		else $error("sector step past end of image");

endmodule

`default_nettype wire

// File: backup/bk_sequencer.sv
`default_nettype none

module bk_sequencer
	import bk_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic img_mounted,
	input  logic img_nonzero,
	input  logic bk_save,
	input  logic cart_download,
	input  logic sd_ack,
	input  logic last_sector,
	output logic sd_rd,
	output logic sd_wr,
	output logic bk_active,
	output logic loading,
	output logic start_load,
	output logic start_save,
	output logic lba_step
);

	// Two-stage history of the edge-detected inputs
	logic [1:0] mount_q;
	logic [1:0] save_q;
	logic [1:0] dl_q;
	logic       sd_ack_d;

	logic       load_pend;
	logic       save_pend;
	bk_state_t  state;

	logic       mount_rise;
	logic       save_rise;
	logic       dl_rise;
	logic       ack_rise;
	logic       ack_fall;

	assign mount_rise = mount_q[0] & ~mount_q[1];
	assign save_rise  = save_q[0] & ~save_q[1];
	assign dl_rise    = dl_q[0] & ~dl_q[1];
	assign ack_rise   = sd_ack & ~sd_ack_d;
	assign ack_fall   = ~sd_ack & sd_ack_d;

	// A pending load always goes before a pending save
	assign start_load = (state == IDLE) && bk_active && load_pend;
	assign start_save = (state == IDLE) && bk_active && save_pend && !load_pend;

	// Counter moves on the same edge the strobe comes back up
	assign lba_step = (state == XFER) && ack_fall && !last_sector;

	// ==================================================
	// Enable flag and per-sector SD protocol
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mount_q   <= '0;
			save_q    <= '0;
			dl_q      <= '0;
			sd_ack_d  <= 1'b0;
			bk_active <= 1'b0;
			load_pend <= 1'b0;
			save_pend <= 1'b0;
			loading   <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			state     <= IDLE;
		end else begin
			mount_q  <= {mount_q[0], img_mounted};
			save_q   <= {save_q[0], bk_save};
			dl_q     <= {dl_q[0], cart_download};
			sd_ack_d <= sd_ack;

			// Empty image disables backup
			if (mount_rise) begin
				bk_active <= img_nonzero;
				load_pend <= img_nonzero;
			end

			if (save_rise && bk_active)
				save_pend <= 1'b1;

			// New cartridge, old save image no longer belongs to it
			if (dl_rise) begin
				bk_active <= 1'b0;
				load_pend <= 1'b0;
				save_pend <= 1'b0;
			end

			// Host has taken the command
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				IDLE: begin
					if (start_load) begin
						state     <= XFER;
						loading   <= 1'b1;
						load_pend <= 1'b0;
						sd_rd     <= 1'b1;
					end else if (start_save) begin
						state     <= XFER;
						loading   <= 1'b0;
						save_pend <= 1'b0;
						sd_wr     <= 1'b1;
					end
				end
				XFER: begin
					// Falling ack closes one sector
					if (ack_fall) begin
						if (last_sector) begin
							state   <= IDLE;
							loading <= 1'b0;
						end else begin
							sd_rd <= loading;
							sd_wr <= ~loading;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Host must never see a read and a write at once
	assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

endmodule

`default_nettype wire

// File: backup/bk_word_port.sv
`default_nettype none

module bk_word_port
	import bk_pkg::*;
#(
	parameter int ADDR_W = 19
)
(
	input  logic              clk_sys,
	input  logic              reset,
	input  sd_buf_t           sd_buf,
	input  logic              start_load,
	input  logic              start_save,
	input  logic              loading,
	input  logic [WORD_W-1:0] mem_dout,
	output logic [BYTE_W-1:0] sd_buff_din,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [WORD_W-1:0] mem_din,
	output logic              mem_we,
	output logic              mem_req
);

	// Word read back from memory for the save direction
	logic [WORD_W-1:0] q_save;

	logic              wr_pend;
	logic              adv_pend;
	logic              rd_pend;
	logic              odd_byte;

	assign odd_byte    = sd_buf.addr[0];
	assign sd_buff_din = odd_byte ? q_save[WORD_W-1:BYTE_W] : q_save[BYTE_W-1:0];

	// ==================================================
	// Request toggle and address sequencing
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_addr <= '0;
			mem_we   <= 1'b0;
			mem_req  <= 1'b0;
			wr_pend  <= 1'b0;
			adv_pend <= 1'b0;
			rd_pend  <= 1'b0;
		end else begin
			wr_pend  <= loading && sd_buf.wr && odd_byte;
			adv_pend <= wr_pend;
			rd_pend  <= 1'b0;

			// Load, write one cycle after the high byte, step one cycle later
			if (wr_pend)
				mem_req <= ~mem_req;
			if (adv_pend)
				mem_addr <= mem_addr + 1'b1;

			// Save, odd byte gone so fetch the next word
			if (!loading && sd_buf.rd && odd_byte) begin
				mem_addr <= mem_addr + 1'b1;
				rd_pend  <= 1'b1;
			end
			if (rd_pend)
				mem_req <= ~mem_req;

			if (start_load) begin
				mem_addr <= '0;
				mem_we   <= 1'b1;
			end else if (start_save) begin
				// Prefetch word 0 right away
				mem_addr <= '0;
				mem_we   <= 1'b0;
				mem_req  <= ~mem_req;
			end
		end
	end

	// Byte packing and read-back hold
	always_ff @(posedge clk_sys) begin
		if (loading && sd_buf.wr) begin
			if (odd_byte)
				mem_din[WORD_W-1:BYTE_W] <= sd_buf.dout;
			else
				mem_din[BYTE_W-1:0] <= sd_buf.dout;
		end

		// Frozen while the card reads the high byte
		if (!odd_byte)
			q_save <= mem_dout;
	end

	// Memory needs at least two cycles between requests
	assert property (@(posedge clk_sys) disable iff (reset) $changed(mem_req) |=> $stable(mem_req))
		else $error("mem_req toggled on consecutive cycles");

endmodule

`default_nettype wire

// File: common/bk_pkg.sv
`default_nettype none

package bk_pkg;

	// ==================================================
	// Widths shared by the backup blocks
	// ==================================================

	// Byte offset inside one 512-byte sector
	localparam int SECTOR_BYTES_W = 9;

	// One SD buffer byte
	localparam int BYTE_W = 8;

	// Backup memory word, two SD bytes in little-endian order
	localparam int WORD_W = 16;

	// ==================================================
	// SD buffer side, driven by the SD host
	// ==================================================

	typedef struct packed {
		// Byte index inside the current sector
		logic [SECTOR_BYTES_W-1:0] addr;
		// Byte coming from the card on a load
		logic [BYTE_W-1:0]         dout;
		// Strobe, dout holds a new byte
		logic                      wr;
		// Strobe, the card has taken sd_buff_din
		logic                      rd;
	} sd_buf_t;

	// Sequencer states
	typedef enum logic {
		IDLE,
		XFER
	} bk_state_t;

endpackage

`default_nettype wire

// File: flist.f
common/bk_pkg.sv
backup/bk_sequencer.sv
backup/bk_lba_counter.sv
backup/bk_word_port.sv
source/bk_backup_top.sv
sim/tb_models.sv
sim/tb_backup.sv

// File: sim/tb_backup.sv
`default_nettype none

module tb_backup
	import bk_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W = 19;
	localparam int LBA_W  = 12;
	localparam int N_ROWS = 7;

	typedef enum logic [1:0] {
		ACT_SAVE,
		ACT_MOUNT,
		ACT_DOWNLOAD
	} action_t;

	// Sectors is the image size on a mount and the expected transfer length
	typedef struct packed {
		action_t    action;
		logic [3:0] sectors;
		logic       exp_active;
	} scenario_t;

	logic              clk_sys;
	logic              reset;
	logic              img_mounted;
	logic [31:0]       img_size;
	logic              sd_ack;
	sd_buf_t           sd_buf;
	logic [LBA_W-1:0]  sd_lba;
	logic              sd_rd;
	logic              sd_wr;
	logic [BYTE_W-1:0] sd_buff_din;
	logic              bk_save;
	logic              cart_download;
	logic              bk_active;
	logic [ADDR_W-1:0] mem_addr;
	logic [WORD_W-1:0] mem_din;
	logic              mem_we;
	logic              mem_req;
	logic [WORD_W-1:0] mem_dout;

	scenario_t rows [N_ROWS];
	int        cycle_cnt = 0;
	int        sector_reqs = 0;
	logic      strobe_d = 1'b0;
	int        cycle_limit;
	int        err_cnt;
	int        tests_failed;

	bk_backup_top #(.ADDR_W(ADDR_W), .LBA_W(LBA_W)) u_bk_backup_top (
		.clk_sys(clk_sys), .reset(reset), .img_mounted(img_mounted), .img_size(img_size),
		.sd_ack(sd_ack), .sd_buf(sd_buf), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_buff_din(sd_buff_din), .bk_save(bk_save), .cart_download(cart_download),
		.bk_active(bk_active), .mem_addr(mem_addr), .mem_din(mem_din), .mem_we(mem_we),
		.mem_req(mem_req), .mem_dout(mem_dout)
	);

	sd_host_model #(.LBA_W(LBA_W)) u_sd (
		.clk_sys(clk_sys), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_buff_din(sd_buff_din), .sd_ack(sd_ack), .sd_buf(sd_buf)
	);

	mem_model #(.ADDR_W(ADDR_W)) u_mem (
		.clk_sys(clk_sys), .mem_addr(mem_addr), .mem_din(mem_din), .mem_we(mem_we),
		.mem_req(mem_req), .mem_dout(mem_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Each rising sd_rd or sd_wr is one sector command from the DUT
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		strobe_d  <= sd_rd | sd_wr;
		if ((sd_rd || sd_wr) && !strobe_d)
			sector_reqs <= sector_reqs + 1;
	end

	initial begin
		#1;
		while (cycle_cnt < cycle_limit)
			@(posedge clk_sys);
		$display("Timeout after %0d cycles, a transfer never finished", cycle_cnt);
		$display("Something failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	function automatic string describe_action(input action_t action);
		case (action)
			ACT_SAVE:  return "save";
			ACT_MOUNT: return "mount";
			default:   return "download";
		endcase
	endfunction

	// Holds the level for two cycles from 1 ns after an edge
	task automatic pulse_input(input action_t action, input logic [3:0] sectors);
		case (action)
			ACT_SAVE:  bk_save = 1'b1;
			ACT_MOUNT: begin
				img_size    = 32'(sectors) << SECTOR_BYTES_W;
				img_mounted = 1'b1;
			end
			default:   cart_download = 1'b1;
		endcase
		repeat (2) @(posedge clk_sys);
		#1;
		bk_save       = 1'b0;
		img_mounted   = 1'b0;
		cart_download = 1'b0;
	endtask

	// Sector order and words packed little-endian from the streamed bytes
	task automatic check_load(input int sect_base, input int sent_base, input int n);
		logic [WORD_W-1:0] exp;
		for (int s = 0; s < n; s++)
			check_value("sd_lba", 32'(u_sd.lba_log[(sect_base + s) % 16]), 32'(s));
		for (int k = 0; k < n * 256; k++) begin
			exp = {u_sd.sent_bytes[sent_base + 2 * k + 1], u_sd.sent_bytes[sent_base + 2 * k]};
			check_value($sformatf("mem[%0d]", k), 32'(u_mem.mem[k]), 32'(exp));
		end
	endtask

	task automatic check_save(input int got_base, input int n);
		logic [WORD_W-1:0] word;
		logic [BYTE_W-1:0] exp;
		for (int j = 0; j < n * 512; j++) begin
			word = u_mem.mem[j / 2];
			exp  = j[0] ? word[WORD_W-1:BYTE_W] : word[BYTE_W-1:0];
			check_value($sformatf("sd_buff_din byte %0d", j),
				32'(u_sd.got_bytes[got_base + j]), 32'(exp));
		end
	endtask

	task automatic run_row(input int idx);
		scenario_t row;
		int        sect_base;
		int        sent_base;
		int        got_base;
		int        req_base;
		int        err_base;
		row       = rows[idx];
		sect_base = u_sd.n_sectors;
		sent_base = u_sd.n_sent;
		got_base  = u_sd.n_got;
		req_base  = sector_reqs;
		err_base  = err_cnt;
		pulse_input(row.action, row.sectors);
		// Looked at on the edge itself, before the DUT and the models move on
		while (u_sd.n_sectors != sect_base + int'(row.sectors) || sd_rd || sd_wr)
			@(posedge clk_sys);
		// Long enough for a stray extra sector command to show up
		repeat (20) @(posedge clk_sys);
		#1;
		check_value("bk_active", 32'(bk_active), 32'(row.exp_active));
		check_value("sector commands", 32'(sector_reqs - req_base), 32'(row.sectors));
		if (row.action == ACT_MOUNT)
			check_load(sect_base, sent_base, int'(row.sectors));
		else if (row.action == ACT_SAVE)
			check_save(got_base, int'(row.sectors));
		if (err_cnt != err_base)
			tests_failed++;
		$display("test %0d %s, %0d sectors: %s", idx, describe_action(row.action),
			row.sectors, (err_cnt == err_base) ? "ok" : "FAILED");
	endtask

	initial begin
		reset         = 1'b1;
		img_mounted   = 1'b0;
		img_size      = '0;
		bk_save       = 1'b0;
		cart_download = 1'b0;
		err_cnt       = 0;
		tests_failed  = 0;

		// Save before any mount, load, save back, download, then an empty image
		rows[0] = '{ACT_SAVE,     4'd0, 1'b0};
		rows[1] = '{ACT_MOUNT,    4'd3, 1'b1};
		rows[2] = '{ACT_SAVE,     4'd3, 1'b1};
		rows[3] = '{ACT_DOWNLOAD, 4'd0, 1'b0};
		rows[4] = '{ACT_SAVE,     4'd0, 1'b0};
		rows[5] = '{ACT_MOUNT,    4'd0, 1'b0};
		rows[6] = '{ACT_SAVE,     4'd0, 1'b0};

		cycle_limit = 2000;
		for (int i = 0; i < N_ROWS; i++)
			cycle_limit += int'(rows[i].sectors) * 512 * 4;

		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		for (int i = 0; i < N_ROWS; i++)
			run_row(i);

		$display("%0d tests, %0d failed, %0d failed checks", N_ROWS, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tb_models.sv
`default_nettype none

// ==================================================
// SD card host, four cycles per byte strobe
// ==================================================

module sd_host_model
	import bk_pkg::*;
#(
	parameter int LBA_W = 12
)
(
	input  logic              clk_sys,
	input  logic [LBA_W-1:0]  sd_lba,
	input  logic              sd_rd,
	input  logic              sd_wr,
	input  logic [BYTE_W-1:0] sd_buff_din,
	output logic              sd_ack,
	output sd_buf_t           sd_buf
);
	timeunit 1ns;
	timeprecision 100ps;

	// Bytes sent on loads and captured on saves, in stream order
	logic [BYTE_W-1:0] sent_bytes [0:2047];
	logic [BYTE_W-1:0] got_bytes [0:2047];
	logic [LBA_W-1:0]  lba_log [0:15];
	int                n_sectors;
	int                n_sent;
	int                n_got;
	logic [31:0]       pattern;
	logic [BYTE_W-1:0] data;
	logic              is_load;

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] next_pattern_state(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial begin
		sd_ack    = 1'b0;
		sd_buf    = '0;
		n_sectors = 0;
		n_sent    = 0;
		n_got     = 0;
		data      = '0;
		pattern   = 32'he89d22c1;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				is_load = sd_rd;
				lba_log[n_sectors[3:0]] = sd_lba;
				sd_ack = 1'b1;
				repeat (2) @(posedge clk_sys);
				for (int i = 0; i < 512; i++) begin
					@(posedge clk_sys);
					#1;
					sd_buf.addr = SECTOR_BYTES_W'(i);
					@(posedge clk_sys);
					#1;
					if (is_load) begin
						// One new pattern bit per shift
						for (int b = 0; b < BYTE_W; b++) begin
							pattern = next_pattern_state(pattern);
							data = {data[BYTE_W-2:0], pattern[0]};
						end
						sd_buf.dout = data;
						sent_bytes[n_sent] = data;
						n_sent++;
						sd_buf.wr = 1'b1;
					end else begin
						got_bytes[n_got] = sd_buff_din;
						n_got++;
						sd_buf.rd = 1'b1;
					end
					@(posedge clk_sys);
					#1;
					sd_buf.wr = 1'b0;
					sd_buf.rd = 1'b0;
					@(posedge clk_sys);
				end
				@(posedge clk_sys);
				#1;
				sd_ack = 1'b0;
				n_sectors++;
			end
		end
	end

endmodule

// ==================================================
// Backup memory, answers a request toggle in one cycle
// ==================================================

module mem_model
	import bk_pkg::*;
#(
	parameter int ADDR_W = 19
)
(
	input  logic              clk_sys,
	input  logic [ADDR_W-1:0] mem_addr,
	input  logic [WORD_W-1:0] mem_din,
	input  logic              mem_we,
	input  logic              mem_req,
	output logic [WORD_W-1:0] mem_dout
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [WORD_W-1:0] mem [0:4095];
	logic              req_d;

	initial begin
		req_d    = 1'b0;
		mem_dout = '0;
		// Odd multiplier keeps every word of the array distinct
		for (int k = 0; k < 4096; k++)
			mem[k] = WORD_W'(k * 16'h9e37) ^ 16'hc3a5;
	end

	always @(posedge clk_sys) begin
		req_d <= mem_req;
		if (mem_req != req_d) begin
			if (mem_we)
				mem[mem_addr[11:0]] <= mem_din;
			else
				mem_dout <= mem[mem_addr[11:0]];
		end
	end

endmodule

`default_nettype wire

// File: source/bk_backup_top.sv
`default_nettype none

module bk_backup_top
	import bk_pkg::*;
#(
	parameter int ADDR_W = 19,
	parameter int LBA_W  = 12
)
(
	input  logic              clk_sys,
	input  logic              reset,

	// SD host side
	input  logic              img_mounted,
	input  logic [31:0]       img_size,
	input  logic              sd_ack,
	input  sd_buf_t           sd_buf,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic [BYTE_W-1:0] sd_buff_din,

	// User controls
	input  logic              bk_save,
	input  logic              cart_download,
	output logic              bk_active,

	// Backup memory port
	output logic [ADDR_W-1:0] mem_addr,
	output logic [WORD_W-1:0] mem_din,
	output logic              mem_we,
	output logic              mem_req,
	input  logic [WORD_W-1:0] mem_dout
);

	logic img_nonzero;
	logic last_sector;
	logic loading;
	logic start_load;
	logic start_save;
	logic lba_step;

	bk_sequencer u_bk_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.img_mounted   (img_mounted),
		.img_nonzero   (img_nonzero),
		.bk_save       (bk_save),
		.cart_download (cart_download),
		.sd_ack        (sd_ack),
		.last_sector   (last_sector),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_active     (bk_active),
		.loading       (loading),
		.start_load    (start_load),
		.start_save    (start_save),
		.lba_step      (lba_step)
	);

	bk_lba_counter #(.LBA_W(LBA_W)) u_bk_lba_counter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.clear       (start_load | start_save),
		.step        (lba_step),
		.sd_lba      (sd_lba),
		.last_sector (last_sector),
		.img_nonzero (img_nonzero)
	);

	bk_word_port #(.ADDR_W(ADDR_W)) u_bk_word_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sd_buf      (sd_buf),
		.start_load  (start_load),
		.start_save  (start_save),
		.loading     (loading),
		.mem_dout    (mem_dout),
		.sd_buff_din (sd_buff_din),
		.mem_addr    (mem_addr),
		.mem_din     (mem_din),
		.mem_we      (mem_we),
		.mem_req     (mem_req)
	);

endmodule

`default_nettype wire
